/* rtl/zmem_pkg.sv */
package zmem_pkg;

	// bus and address widths
	localparam int za_w    = 16; // z80 address bus
	localparam int page_w  = 8;  // page number per 16k window
	localparam int dram_aw = 21; // page + za[13:1]

	// z80 clock rate
	typedef enum logic [1:0] {
		turbo_35,
		turbo_7,
		turbo_14
	} turbo_t;

	// kind of the z80 memory cycle, decoded from the bus strobes
	typedef enum logic [1:0] {
		acc_none,  // no cycle or refresh
		acc_fetch, // m1 opcode fetch
		acc_read,
		acc_write
	} access_t;

	// request and stall sequencer
	typedef enum logic [1:0] {
		st_idle,
		st_wait_slot, // 14 mhz, waiting for accept
		st_finish,    // read data on its way
		st_slow_wait  // 7/3.5 mhz, waiting for accept
	} stall_state_t;

endpackage

/* rtl/zmem_dram_if.sv */
`timescale 1ns/1ps

interface zmem_dram_if;

	logic                         req;    // held until c6 && next
	logic                         rnw;    // 1 read, 0 write
	logic [zmem_pkg::dram_aw-1:0] addr;   // word address
	logic [7:0]                   wrdata;
	logic                         wrbsel; // 1 selects low byte
	logic [15:0]                  rddata;
	logic                         next;   // slot free for cpu
	logic                         strobe; // rddata valid

	// memory manager side
	modport mgr (
		output req, rnw, addr, wrdata, wrbsel,
		input  rddata, next, strobe
	);

	// controller side
	modport dram (
		input  req, rnw, addr, wrdata, wrbsel,
		output rddata, next, strobe
	);

endinterface

/* rtl/zclk_phase_timer.sv */
`timescale 1ns/1ps

module zclk_phase_timer (
	input  logic             fclk,
	input  logic             rst_n,
	input  zmem_pkg::turbo_t turbo,
	input  logic             stall,
	output logic             c0,
	output logic             c2,
	output logic             c4,
	output logic             c6,
	output logic             zpos, // zclk rises after this cycle
	output logic             zneg, // zclk falls after this cycle
	output logic             zclk
);

	logic [2:0] phase; // dram cycle phase, free running
	logic [2:0] zcnt;  // half period divider
	logic [2:0] zterm;
	logic       ztc;

	always_comb
	begin
		case (turbo)
			zmem_pkg::turbo_14: zterm = 3'd1; // 4 fclk period
			zmem_pkg::turbo_7:  zterm = 3'd3; // 8 fclk
			default:            zterm = 3'd7; // 16 fclk
		endcase
	end

	assign ztc  = (zcnt >= zterm) && !stall; // frozen while stalled
	assign zpos = ztc && !zclk;
	assign zneg = ztc && zclk;

	assign c0 = (phase == 3'd0);
	assign c2 = (phase == 3'd2);
	assign c4 = (phase == 3'd4);
	assign c6 = (phase == 3'd6);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			phase <= 3'd0;
			zcnt  <= 3'd0;
			zclk  <= 1'b0;
		end
		else
		begin
			phase <= phase + 3'd1;
			if (ztc)
			begin
				zcnt <= 3'd0;
				zclk <= !zclk; // edge announced by zpos/zneg
			end
			else if (!stall)
				zcnt <= zcnt + 3'd1;
		end
	end

endmodule

/* rtl/zmem_pager.sv */
`timescale 1ns/1ps

module zmem_pager (
	input  logic [zmem_pkg::za_w-1:0]         za,
	input  logic [7:0]                        zd_in,
	input  logic                              rd_n,
	input  logic                              wr_n,
	input  logic                              mreq_n,
	input  logic [3:0]                        win_romnram, // 1 rom, 0 ram
	input  logic [3:0][zmem_pkg::page_w-1:0]  win_page,
	input  logic                              romrw_en,    // flash write allowed
	output logic [4:0]                        rompg,
	output logic                              csrom,
	output logic                              romoe_n,
	output logic                              romwe_n,
	output logic                              romnram,
	zmem_dram_if.mgr                          dram
);

	logic [1:0]                  win;
	logic [zmem_pkg::page_w-1:0] page;

	assign win = za[15:14]; // 16k window number

	always_comb
	begin
		page    = win_page[win];
		romnram = win_romnram[win];
	end

	// rom side, 512k reachable
	assign rompg   = page[4:0];
	assign csrom   = romnram && !mreq_n; // active high
	assign romoe_n = rd_n || mreq_n || !romnram;
	assign romwe_n = wr_n || mreq_n || !romnram || !romrw_en;

	// dram word address and write byte
	assign dram.addr   = {page, za[13:1]};
	assign dram.wrdata = zd_in;
	assign dram.wrbsel = za[0]; // odd byte is the low half

endmodule

/* rtl/zmem_rdcache.sv */
`timescale 1ns/1ps

module zmem_rdcache (
	input  logic                      fclk,
	input  logic                      rst_n,
	input  logic [zmem_pkg::za_w-1:0] za,
	input  zmem_pkg::access_t         access,
	input  logic                      romnram,
	input  logic                      iorq_n,
	input  logic                      zpos,
	input  logic                      zneg,
	input  logic                      mreq_first, // first zneg of a mem cycle
	input  logic                      strobe,
	input  logic [15:0]               rddata,
	output logic                      cache_hit,
	output logic [7:0]                zd_out,
	output logic                      zd_ena
);

	logic [15:0] rd_buf;      // last word from dram
	logic [15:1] cached_addr;
	logic        valid;
	logic        io_r;        // iorq seen at last zclk edge
	logic        io_new;
	logic        flush;

	assign io_new = !iorq_n && !io_r && (zpos || zneg);
	assign flush  = (mreq_first && (romnram || access == zmem_pkg::acc_write)) || io_new;

	assign cache_hit = valid && (cached_addr == za[15:1]);
	assign zd_out    = za[0] ? rd_buf[7:0] : rd_buf[15:8];
	assign zd_ena    = !romnram &&
		(access == zmem_pkg::acc_read || access == zmem_pkg::acc_fetch);

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid <= 1'b0;
			io_r  <= 1'b0;
		end
		else
		begin
			if (zpos || zneg)
				io_r <= !iorq_n;
			if (flush)
				valid <= 1'b0; // flush wins over a late strobe
			else if (strobe)
				valid <= 1'b1;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (strobe)
		begin
			rd_buf      <= rddata;
			cached_addr <= za[15:1]; // z80 is stalled, za still valid
		end
	end

endmodule

/* rtl/zmem_stall_fsm.sv */
`timescale 1ns/1ps

module zmem_stall_fsm (
	input  logic              fclk,
	input  logic              rst_n,
	input  zmem_pkg::turbo_t  turbo,
	input  zmem_pkg::access_t access,
	input  logic              romnram,
	input  logic              cache_hit,
	input  logic              zneg,
	input  logic              c2,
	input  logic              c4,
	input  logic              c6,
	output logic              mreq_first,
	output logic              cpu_stall,
	zmem_dram_if.mgr          dram
);

	zmem_pkg::stall_state_t state;
	zmem_pkg::stall_state_t state_nx;

	logic mem_acc;  // memory cycle on the bus
	logic fast;     // 14 mhz
	logic zseen;    // memory cycle already there at last zneg
	logic cyc_done; // this cycle already handled
	logic start;
	logic accept;
	logic fin_end;
	logic rnw_r;
	logic fetch_r;

	assign mem_acc    = (access != zmem_pkg::acc_none);
	assign fast       = (turbo == zmem_pkg::turbo_14);
	assign mreq_first = zneg && mem_acc && !zseen;
	assign accept     = c6 && dram.next;
	assign fin_end    = fetch_r ? c4 : c2; // fetch gets one more phase

	// 14 mhz waits for the opening zneg, slow rates go on the first fclk
	assign start = (state == zmem_pkg::st_idle) && mem_acc && !romnram && !cyc_done &&
		(access == zmem_pkg::acc_write || !cache_hit) && (fast ? mreq_first : 1'b1);

	always_comb
	begin
		state_nx = state;
		case (state)
			zmem_pkg::st_idle:
				if (start)
					state_nx = fast ? zmem_pkg::st_wait_slot : zmem_pkg::st_slow_wait;
			zmem_pkg::st_wait_slot:
				if (accept)
					state_nx = rnw_r ? zmem_pkg::st_finish : zmem_pkg::st_idle;
			zmem_pkg::st_slow_wait:
				if (accept)
					state_nx = zmem_pkg::st_idle; // slow zclk leaves time for the strobe
			default:
				if (fin_end)
					state_nx = zmem_pkg::st_idle; // data in read buffer
		endcase
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= zmem_pkg::st_idle;
			zseen    <= 1'b0;
			cyc_done <= 1'b0;
		end
		else
		begin
			state    <= state_nx;
			cyc_done <= mem_acc && (cyc_done || start || mreq_first);
			if (zneg)
				zseen <= mem_acc;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (start)
		begin
			rnw_r   <= (access != zmem_pkg::acc_write);
			fetch_r <= (access == zmem_pkg::acc_fetch);
		end
	end

	assign dram.req = (state == zmem_pkg::st_wait_slot) || (state == zmem_pkg::st_slow_wait);
	assign dram.rnw = rnw_r;
	assign cpu_stall = (state != zmem_pkg::st_idle); // zclk held while busy

endmodule

/* rtl/dram_slot_ctrl.sv */
`timescale 1ns/1ps

module dram_slot_ctrl #(
	parameter int VIDEO_EVERY     = 2,  // one video cycle per this many
	parameter int DRAM_DEPTH_LOG2 = 12  // stored word address bits
) (
	input  logic      fclk,
	input  logic      rst_n,
	input  logic      c0,
	input  logic      c2,
	input  logic      c6,
	zmem_dram_if.dram dram,
	output logic      cpu_slot_used
);

	localparam int SLOT_W = (VIDEO_EVERY > 1) ? $clog2(VIDEO_EVERY) : 1;

	logic [15:0]                mem [2**DRAM_DEPTH_LOG2];
	logic [SLOT_W-1:0]          slot_cnt;
	logic                       video;   // current 8-cycle slot is video
	logic                       accept;
	logic                       rd_pend; // strobe due at next c2
	logic [15:0]                rd_word;
	logic [DRAM_DEPTH_LOG2-1:0] widx;

	assign widx        = dram.addr[DRAM_DEPTH_LOG2-1:0];
	assign accept      = c6 && dram.next && dram.req;
	assign dram.next   = !video;
	assign dram.strobe = rd_pend && c2; // 4 fclk after accept
	assign dram.rddata = rd_word;

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			slot_cnt      <= '0;
			video         <= 1'b0;
			rd_pend       <= 1'b0;
			cpu_slot_used <= 1'b0;
		end
		else
		begin
			if (c0)
			begin
				video    <= (slot_cnt == '0);
				slot_cnt <= (slot_cnt == SLOT_W'(VIDEO_EVERY - 1)) ? '0 : slot_cnt + 1'b1;
			end
			if (accept && dram.rnw)
				rd_pend <= 1'b1;
			else if (c2)
				rd_pend <= 1'b0;
			cpu_slot_used <= accept;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (accept && !dram.rnw)
		begin
			if (dram.wrbsel)
				mem[widx][7:0] <= dram.wrdata;
			else
				mem[widx][15:8] <= dram.wrdata;
		end
		if (accept && dram.rnw)
			rd_word <= mem[widx];
	end

endmodule

/* rtl/zmem_top.sv */
`timescale 1ns/1ps

module zmem_top #(
	parameter int VIDEO_EVERY     = 2,
	parameter int DRAM_DEPTH_LOG2 = 12
) (
	input  logic                        fclk,
	input  logic                        rst_n,
	input  zmem_pkg::turbo_t            turbo,
	input  logic [zmem_pkg::za_w-1:0]   za,
	input  logic [7:0]                  zd_in,
	output logic [7:0]                  zd_out,
	output logic                        zd_ena,
	input  logic                        m1_n,
	input  logic                        rfsh_n,
	input  logic                        mreq_n,
	input  logic                        iorq_n,
	input  logic                        rd_n,
	input  logic                        wr_n,
	input  logic                        win0_romnram,
	input  logic                        win1_romnram,
	input  logic                        win2_romnram,
	input  logic                        win3_romnram,
	input  logic [zmem_pkg::page_w-1:0] win0_page,
	input  logic [zmem_pkg::page_w-1:0] win1_page,
	input  logic [zmem_pkg::page_w-1:0] win2_page,
	input  logic [zmem_pkg::page_w-1:0] win3_page,
	input  logic                        romrw_en,
	output logic [4:0]                  rompg,
	output logic                        romoe_n,
	output logic                        romwe_n,
	output logic                        csrom,
	output logic                        zclk,
	output logic                        cpu_stall,
	output logic                        cpu_slot_used
);

	zmem_pkg::access_t access;

	logic c0, c2, c4, c6;
	logic zpos, zneg;
	logic romnram;
	logic cache_hit;
	logic mreq_first;

	zmem_dram_if dram_bus ();

	// refresh cycles are not memory accesses
	always_comb
	begin
		if (mreq_n || !rfsh_n)
			access = zmem_pkg::acc_none;
		else if (!m1_n)
			access = zmem_pkg::acc_fetch;
		else if (!rd_n)
			access = zmem_pkg::acc_read;
		else if (!wr_n)
			access = zmem_pkg::acc_write;
		else
			access = zmem_pkg::acc_none; // mreq before rd/wr
	end

	zclk_phase_timer u_timer (
		.fclk(fclk), .rst_n(rst_n), .turbo(turbo), .stall(cpu_stall),
		.c0(c0), .c2(c2), .c4(c4), .c6(c6), .zpos(zpos), .zneg(zneg), .zclk(zclk)
	);

	zmem_pager u_pager (
		.za(za), .zd_in(zd_in), .rd_n(rd_n), .wr_n(wr_n), .mreq_n(mreq_n),
		.win_romnram({win3_romnram, win2_romnram, win1_romnram, win0_romnram}),
		.win_page({win3_page, win2_page, win1_page, win0_page}),
		.romrw_en(romrw_en), .rompg(rompg), .csrom(csrom), .romoe_n(romoe_n),
		.romwe_n(romwe_n), .romnram(romnram), .dram(dram_bus.mgr)
	);

	zmem_rdcache u_rdcache (
		.fclk(fclk), .rst_n(rst_n), .za(za), .access(access), .romnram(romnram),
		.iorq_n(iorq_n), .zpos(zpos), .zneg(zneg), .mreq_first(mreq_first),
		.strobe(dram_bus.strobe), .rddata(dram_bus.rddata),
		.cache_hit(cache_hit), .zd_out(zd_out), .zd_ena(zd_ena)
	);

	zmem_stall_fsm u_fsm (
		.fclk(fclk), .rst_n(rst_n), .turbo(turbo), .access(access), .romnram(romnram),
		.cache_hit(cache_hit), .zneg(zneg), .c2(c2), .c4(c4), .c6(c6),
		.mreq_first(mreq_first), .cpu_stall(cpu_stall), .dram(dram_bus.mgr)
	);

	dram_slot_ctrl #(
		.VIDEO_EVERY(VIDEO_EVERY),
		.DRAM_DEPTH_LOG2(DRAM_DEPTH_LOG2)
	) u_dram (
		.fclk(fclk), .rst_n(rst_n), .c0(c0), .c2(c2), .c6(c6),
		.dram(dram_bus.dram), .cpu_slot_used(cpu_slot_used)
	);

endmodule

/* verification/zmem_assert.sv */
`timescale 1ns/1ps

module zmem_assert (
	input logic                         fclk,
	input logic                         rst_n,
	input zmem_pkg::stall_state_t       state,
	input logic                         cpu_stall,
	input logic                         c6,
	input logic                         req,
	input logic                         rnw,
	input logic [zmem_pkg::dram_aw-1:0] addr,
	input logic                         next,
	input logic                         strobe
);

	// request held with the same kind and address until c6 with a free slot
	req_held: assert property (@(posedge fclk) disable iff (!rst_n)
		req && !(c6 && next) |=> req && $stable(rnw) && $stable(addr))
		else $error("dram request dropped or changed before accept");

	// slow rates stall only until the accept
	slow_stall_ends: assert property (@(posedge fclk) disable iff (!rst_n)
		state == zmem_pkg::st_slow_wait && c6 && next |=> !cpu_stall)
		else $error("cpu_stall held after accept at a slow rate");

	// accept at c6, data strobe at the c2 four fclk later
	rd_strobe: assert property (@(posedge fclk) disable iff (!rst_n)
		$past(req && rnw && c6 && next, 4) |-> strobe)
		else $error("no read strobe 4 cycles after accept");

endmodule

bind zmem_stall_fsm zmem_assert u_assert (
	.fclk(fclk), .rst_n(rst_n), .state(state), .cpu_stall(cpu_stall), .c6(c6),
	.req(dram.req), .rnw(dram.rnw), .addr(dram.addr), .next(dram.next),
	.strobe(dram.strobe)
);

/* verification/zmem_tb.sv */
`timescale 1ns/1ps

module zmem_tb;

	logic                              fclk;
	logic                              rst_n;
	zmem_pkg::turbo_t                  turbo;
	logic [zmem_pkg::za_w-1:0]         za;
	logic [7:0]                        zd_in;
	logic [7:0]                        zd_out;
	logic                              zd_ena;
	logic                              m1_n, rfsh_n, mreq_n, iorq_n, rd_n, wr_n;
	logic [3:0]                        win_rom;       // 1 maps rom into the window
	logic [zmem_pkg::page_w-1:0]       win_page [4];
	logic                              romrw_en;
	logic [4:0]                        rompg;
	logic                              romoe_n, romwe_n, csrom;
	logic                              zclk, cpu_stall, cpu_slot_used;

	integer      seed;
	int          slot_pulses; // cpu_slot_used pulses since reset
	int          n_checked;
	logic [7:0]  model [logic [21:0]]; // {page, offset} -> byte
	logic [7:0]  got_q [$];
	logic [7:0]  exp_q [$];
	logic [15:0] addr_q [$];
	// bus values as seen at the rising zclk that ends a cycle
	logic [7:0]  smp_zd;
	logic [4:0]  smp_rompg;
	logic        smp_ena, smp_csrom, smp_oe, smp_we;

	zmem_top #(.VIDEO_EVERY(2), .DRAM_DEPTH_LOG2(12)) dut (
		.fclk(fclk), .rst_n(rst_n), .turbo(turbo), .za(za), .zd_in(zd_in),
		.zd_out(zd_out), .zd_ena(zd_ena), .m1_n(m1_n), .rfsh_n(rfsh_n),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.win0_romnram(win_rom[0]), .win1_romnram(win_rom[1]),
		.win2_romnram(win_rom[2]), .win3_romnram(win_rom[3]),
		.win0_page(win_page[0]), .win1_page(win_page[1]),
		.win2_page(win_page[2]), .win3_page(win_page[3]),
		.romrw_en(romrw_en), .rompg(rompg), .romoe_n(romoe_n), .romwe_n(romwe_n),
		.csrom(csrom), .zclk(zclk), .cpu_stall(cpu_stall), .cpu_slot_used(cpu_slot_used)
	);

	initial
	begin
		fclk = 1'b0;
		forever #2 fclk = ~fclk; // 4 ns
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			fail_now($sformatf("ERR %0t %s got %h exp %h", $time, name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_now($sformatf("ERR %0t %s got %b exp %b", $time, name, got, exp));
	endtask

	task automatic check_turbo_slots(input zmem_pkg::turbo_t mode, input int got, input int exp);
		if (got != exp)
			fail_now($sformatf("ERR %0t cpu_slot_used count (%s) got %0d exp %0d",
				$time, mode.name(), got, exp));
	endtask

	// byte the z80 should see, from window setup and earlier writes
	function automatic logic [7:0] ref_read(input logic [15:0] addr);
		logic [21:0] key;
		key = {win_page[addr[15:14]], addr[13:0]};
		if (model.exists(key))
			return model[key];
		return 8'hxx; // never written
	endfunction

	// sampled 1 ns after the edge, returns there too
	task automatic wait_zclk(input logic lvl);
		int n;
		n = 0;
		do
		begin
			@(posedge fclk);
			#1;
			n++;
		end
		while (zclk !== lvl && n < 200);
		if (zclk !== lvl)
			fail_now($sformatf("timeout: zclk stuck at %b for 200 fclk cycles", zclk));
	endtask

	task automatic bus_cycle(input logic [15:0] addr, input zmem_pkg::access_t kind,
		input logic [7:0] wdata);
		za     = addr;
		zd_in  = wdata;
		m1_n   = (kind != zmem_pkg::acc_fetch);
		rd_n   = (kind == zmem_pkg::acc_write);
		wr_n   = (kind != zmem_pkg::acc_write);
		mreq_n = 1'b0;
		wait_zclk(1'b1);
		wait_zclk(1'b0); // stretched low while stalled
		wait_zclk(1'b1); // z80 takes data here
		smp_zd    = zd_out;
		smp_ena   = zd_ena;
		smp_csrom = csrom;
		smp_oe    = romoe_n;
		smp_we    = romwe_n;
		smp_rompg = rompg;
		mreq_n = 1'b1;
		m1_n   = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		wait_zclk(1'b0); // idle falling edge between cycles
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		bus_cycle(addr, zmem_pkg::acc_write, data);
		if (!win_rom[addr[15:14]])
			model[{win_page[addr[15:14]], addr[13:0]}] = data;
	endtask

	task automatic mem_read(input logic [15:0] addr);
		bus_cycle(addr, zmem_pkg::acc_read, 8'h00);
		check_bit("zd_ena", smp_ena, 1'b1);
		got_q.push_back(smp_zd);
		exp_q.push_back(ref_read(addr));
		addr_q.push_back(addr);
	endtask

	task automatic op_fetch(input logic [15:0] addr);
		bus_cycle(addr, zmem_pkg::acc_fetch, 8'h00);
		check_bit("zd_ena", smp_ena, 1'b1);
		got_q.push_back(smp_zd);
		exp_q.push_back(ref_read(addr));
		addr_q.push_back(addr);
	endtask

	task automatic io_cycle();
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		wait_zclk(1'b1);
		wait_zclk(1'b0);
		wait_zclk(1'b1);
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wait_zclk(1'b0);
	endtask

	// 16 words over all four ram windows, za[12:9] keeps the stored words apart
	task automatic ram_round(input zmem_pkg::turbo_t mode);
		logic [15:0] addr [16];
		logic [31:0] r;
		turbo   = mode;
		win_rom = 4'b0000;
		for (int w = 0; w < 4; w++)
		begin
			r = $random(seed);
			win_page[w] = r[7:0];
		end
		for (int i = 0; i < 16; i++)
		begin
			r = $random(seed);
			addr[i] = {i[3:2], r[13], i[3:0], r[8:1], 1'b0};
			mem_write(addr[i], r[23:16]);
			mem_write(addr[i] | 16'h0001, r[31:24]); // other half of the word
		end
		for (int i = 0; i < 16; i++)
		begin
			mem_read(addr[i]);
			op_fetch(addr[i] | 16'h0001);
		end
	endtask

	always @(negedge fclk)
	begin
		if (cpu_slot_used)
			slot_pulses++;
		if (n_checked < got_q.size())
		begin
			check_byte($sformatf("zd_out[%h]", addr_q[n_checked]), got_q[n_checked],
				exp_q[n_checked]);
			n_checked++;
		end
	end

	initial
	begin
		int          base;
		logic [31:0] r;
		seed     = 32'h42f3d764;
		rst_n    = 1'b0;
		turbo    = zmem_pkg::turbo_14;
		za       = '0;
		zd_in    = '0;
		m1_n     = 1'b1;
		rfsh_n   = 1'b1;
		mreq_n   = 1'b1;
		iorq_n   = 1'b1;
		rd_n     = 1'b1;
		wr_n     = 1'b1;
		win_rom  = 4'b0000;
		romrw_en = 1'b0;
		for (int w = 0; w < 4; w++)
			win_page[w] = 8'(w);
		repeat (8) @(posedge fclk);
		#1;
		rst_n = 1'b1;
		@(posedge fclk);
		#1;
		check_bit("zd_ena", zd_ena, 1'b0);
		check_bit("cpu_stall", cpu_stall, 1'b0);
		check_bit("csrom", csrom, 1'b0);
		check_bit("romoe_n", romoe_n, 1'b1);
		check_bit("romwe_n", romwe_n, 1'b1);
		check_bit("zclk", zclk, 1'b0);
		check_bit("cpu_slot_used", cpu_slot_used, 1'b0);
		ram_round(zmem_pkg::turbo_14);

		// window 1 as rom, page 0x35
		win_rom[1]  = 1'b1;
		win_page[1] = 8'h35;
		base = slot_pulses;
		bus_cycle(16'h4123, zmem_pkg::acc_read, 8'h00);
		check_bit("csrom", smp_csrom, 1'b1);
		check_bit("romoe_n", smp_oe, 1'b0);
		check_bit("romwe_n", smp_we, 1'b1);
		check_bit("zd_ena", smp_ena, 1'b0);
		check_byte("rompg", {3'b000, smp_rompg}, {3'b000, win_page[1][4:0]});
		mem_write(16'h4124, 8'h5a); // flash write locked
		check_bit("romwe_n", smp_we, 1'b1);
		romrw_en = 1'b1;
		mem_write(16'h4124, 8'ha5);
		check_bit("romwe_n", smp_we, 1'b0);
		check_turbo_slots(turbo, slot_pulses - base, 0);
		romrw_en   = 1'b0;
		win_rom[1] = 1'b0;

		// read buffer hits and flushes, word w at 8a40, word v at 8c40
		r = $random(seed);
		mem_write(16'h8a40, r[7:0]);
		mem_write(16'h8a41, r[15:8]);
		mem_write(16'h8c40, r[23:16]);
		base = slot_pulses;
		mem_read(16'h8a40);
		mem_read(16'h8a41); // served from the buffer
		check_turbo_slots(turbo, slot_pulses - base, 1);
		base = slot_pulses;
		io_cycle();
		mem_read(16'h8a40);
		mem_write(16'h8c40, r[31:24]);
		mem_read(16'h8a41);
		check_turbo_slots(turbo, slot_pulses - base, 3);
		base = slot_pulses;
		mem_write(16'h8c40, r[15:8]);
		mem_read(16'h8a40);
		io_cycle();
		mem_read(16'h8a41);
		check_turbo_slots(turbo, slot_pulses - base, 3);

		ram_round(zmem_pkg::turbo_35);
		ram_round(zmem_pkg::turbo_7);
		ram_round(zmem_pkg::turbo_14);
		repeat (4) @(posedge fclk);
		if (n_checked != got_q.size())
			fail_now("not every read reached the compare process");
		else
			$display("PASS: all tests");
		$finish;
	end

endmodule

/* tb.f */
rtl/zmem_pkg.sv
rtl/zmem_dram_if.sv
rtl/zclk_phase_timer.sv
rtl/zmem_pager.sv
rtl/zmem_rdcache.sv
rtl/zmem_stall_fsm.sv
rtl/dram_slot_ctrl.sv
rtl/zmem_top.sv
verification/zmem_assert.sv
verification/zmem_tb.sv

/* run_verilator.sh */
#!/bin/sh
# build and run the zmem testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module zmem_tb -f tb.f

out=$(./obj_dir/Vzmem_tb 2>&1) || true
printf '%s\n' "$out"

# result decided by the pass line only
printf '%s\n' "$out" | grep -q '^PASS: all tests$'
